// ==== src/isu_pkg.sv ====
package isu_pkg;

    // Datapath widths
    localparam int PC_W    = 64;
    localparam int INSTR_W = 32;
    localparam int PREG_W  = 6;

    // Reorder buffer geometry, ids carry one extra wrap bit
    localparam int ROB_DEPTH = 8;
    localparam int ROB_IDX_W = 3;

    typedef logic [PC_W-1:0]      pc_t;
    typedef logic [INSTR_W-1:0]   instr_t;
    typedef logic [PREG_W-1:0]    preg_t;
    typedef logic [ROB_IDX_W:0]   robid_t;

    typedef enum logic {
        ROB_RUN  = 1'b0,
        ROB_WALK = 1'b1
    } rob_state_t;

endpackage

// ==== src/rob_walk_fsm.sv ====
`timescale 1ns/1ns

module rob_walk_fsm (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 flush_valid,
    input  logic                 rob_empty,
    output isu_pkg::rob_state_t  rob_state,
    output logic                 disp_ok,
    output logic                 walk_step
);
    import isu_pkg::*;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            rob_state <= ROB_RUN;
        end else begin
            case (rob_state)
                ROB_RUN: begin
                    if (flush_valid) begin
                        rob_state <= ROB_WALK;
                    end
                end
                ROB_WALK: begin
                    // Leave once every flushed entry has been walked back
                    if (rob_empty && !flush_valid) begin
                        rob_state <= ROB_RUN;
                    end
                end
                default: rob_state <= ROB_RUN;
            endcase
        end
    end

    assign disp_ok   = (rob_state == ROB_RUN) && !flush_valid;
    assign walk_step = (rob_state == ROB_WALK) && !rob_empty;

endmodule

// ==== src/rob_ptr.sv ====
`timescale 1ns/1ns

module rob_ptr (
    input  logic             clock,
    input  logic             rst_n,
    input  logic             enq,
    input  logic             deq,
    input  logic             walk_step,
    output isu_pkg::robid_t  head,
    output isu_pkg::robid_t  tail,
    output logic             rob_empty,
    output logic             rob_full
);
    import isu_pkg::*;

    // Commit side
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            head <= '0;
        end else if (deq) begin
            head <= head + robid_t'(1);
        end
    end

    // Allocation grows the tail, a walk step pulls it back
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            tail <= '0;
        end else if (walk_step) begin
            tail <= tail - robid_t'(1);
        end else if (enq) begin
            tail <= tail + robid_t'(1);
        end
    end

    assign rob_empty = (head == tail);

    // Same slot index, opposite lap
    assign rob_full = (head[ROB_IDX_W] != tail[ROB_IDX_W]) &&
                      (head[ROB_IDX_W-1:0] == tail[ROB_IDX_W-1:0]);

endmodule

// ==== src/rob_store.sv ====
`timescale 1ns/1ns

module rob_store (
    input  logic             clock,
    input  logic             rst_n,
    input  logic             enq,
    input  isu_pkg::robid_t  enq_id,
    input  isu_pkg::pc_t     enq_pc,
    input  isu_pkg::preg_t   enq_prd,
    input  logic             enq_need_to_wb,
    input  logic             wb_valid,
    input  isu_pkg::robid_t  wb_robid,
    input  isu_pkg::robid_t  head,
    input  isu_pkg::robid_t  tail,
    input  logic             commit_ok,
    input  logic             walk_step,
    output logic             commit_valid,
    output isu_pkg::pc_t     commit_pc,
    output isu_pkg::preg_t   commit_prd,
    output logic             commit_need_to_wb,
    output isu_pkg::robid_t  commit_robid,
    output isu_pkg::preg_t   walk_prd,
    output logic             walk_need_to_wb
);
    import isu_pkg::*;

    logic [ROB_DEPTH-1:0] ent_valid;
    logic [ROB_DEPTH-1:0] ent_complete;
    logic [ROB_DEPTH-1:0] ent_need_to_wb;
    pc_t                  ent_pc [ROB_DEPTH];
    preg_t                ent_prd [ROB_DEPTH];

    logic [ROB_IDX_W-1:0] head_idx;
    logic [ROB_IDX_W-1:0] walk_idx;

    assign head_idx = head[ROB_IDX_W-1:0];
    // Youngest live entry sits just below the tail
    assign walk_idx = tail[ROB_IDX_W-1:0] - 1'b1;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ent_valid    <= '0;
            ent_complete <= '0;
        end else begin
            if (enq) begin
                ent_valid[enq_id[ROB_IDX_W-1:0]]    <= 1'b1;
                ent_complete[enq_id[ROB_IDX_W-1:0]] <= 1'b0;
            end
            if (wb_valid) begin
                ent_complete[wb_robid[ROB_IDX_W-1:0]] <= 1'b1;
            end
            if (commit_valid) begin
                ent_valid[head_idx] <= 1'b0;
            end
            if (walk_step) begin
                ent_valid[walk_idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (enq) begin
            ent_pc[enq_id[ROB_IDX_W-1:0]]         <= enq_pc;
            ent_prd[enq_id[ROB_IDX_W-1:0]]        <= enq_prd;
            ent_need_to_wb[enq_id[ROB_IDX_W-1:0]] <= enq_need_to_wb;
        end
    end

    assign commit_valid      = ent_valid[head_idx] && ent_complete[head_idx] && commit_ok;
    assign commit_pc         = ent_pc[head_idx];
    assign commit_prd        = ent_prd[head_idx];
    assign commit_need_to_wb = ent_need_to_wb[head_idx];
    assign commit_robid      = head;

    assign walk_prd        = ent_prd[walk_idx];
    assign walk_need_to_wb = ent_need_to_wb[walk_idx];

endmodule

// ==== src/busy_table.sv ====
`timescale 1ns/1ns

module busy_table (
    input  logic            clock,
    input  logic            rst_n,
    input  logic            alloc_en,
    input  isu_pkg::preg_t  alloc_prd,
    input  logic            wb_valid,
    input  logic            wb_need_to_wb,
    input  isu_pkg::preg_t  wb_prd,
    input  logic            walk_step,
    input  logic            walk_need_to_wb,
    input  isu_pkg::preg_t  walk_prd,
    input  isu_pkg::preg_t  rs1,
    input  isu_pkg::preg_t  rs2,
    output logic            rs1_busy,
    output logic            rs2_busy
);
    import isu_pkg::*;

    localparam int NUM_PREGS = 2 ** PREG_W;

    logic [NUM_PREGS-1:0] busy;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            if (wb_valid && wb_need_to_wb) begin
                busy[wb_prd] <= 1'b0;
            end
            if (walk_step && walk_need_to_wb) begin
                busy[walk_prd] <= 1'b0;
            end
            // Set last so a new allocation beats a clear
            if (alloc_en) begin
                busy[alloc_prd] <= 1'b1;
            end
        end
    end

    assign rs1_busy = busy[rs1];
    assign rs2_busy = busy[rs2];

endmodule

// ==== src/issue_queue.sv ====
`timescale 1ns/1ns

module issue_queue #(
    parameter int IQ_DEPTH = 4
) (
    input  logic             clock,
    input  logic             rst_n,
    input  logic             enq,
    input  isu_pkg::robid_t  enq_robid,
    input  isu_pkg::pc_t     enq_pc,
    input  isu_pkg::instr_t  enq_instr,
    input  isu_pkg::preg_t   enq_prd,
    input  isu_pkg::preg_t   enq_prs1,
    input  isu_pkg::preg_t   enq_prs2,
    input  logic             enq_src1_is_reg,
    input  logic             enq_src2_is_reg,
    input  logic             rs1_busy,
    input  logic             rs2_busy,
    input  logic             wb_valid,
    input  isu_pkg::preg_t   wb_prd,
    input  logic             flush_valid,
    output logic             iq_full,
    output logic             deq_valid,
    input  logic             deq_ready,
    output isu_pkg::robid_t  deq_robid,
    output isu_pkg::pc_t     deq_pc,
    output isu_pkg::instr_t  deq_instr,
    output isu_pkg::preg_t   deq_prd,
    output isu_pkg::preg_t   deq_prs1,
    output isu_pkg::preg_t   deq_prs2,
    output logic             deq_src1_is_reg,
    output logic             deq_src2_is_reg
);
    import isu_pkg::*;

    localparam int IDX_W = (IQ_DEPTH > 1) ? $clog2(IQ_DEPTH) : 1;

    logic [IQ_DEPTH-1:0] slot_valid;
    logic [IQ_DEPTH-1:0] src1_rdy;
    logic [IQ_DEPTH-1:0] src2_rdy;
    logic [IQ_DEPTH-1:0] slot_ready;
    logic [IQ_DEPTH-1:0] slot_src1_is_reg;
    logic [IQ_DEPTH-1:0] slot_src2_is_reg;
    robid_t              slot_robid [IQ_DEPTH];
    pc_t                 slot_pc [IQ_DEPTH];
    instr_t              slot_instr [IQ_DEPTH];
    preg_t               slot_prd [IQ_DEPTH];
    preg_t               slot_prs1 [IQ_DEPTH];
    preg_t               slot_prs2 [IQ_DEPTH];

    logic [IDX_W-1:0] free_idx;
    logic [IDX_W-1:0] sel_idx;
    logic             enq_rdy1;
    logic             enq_rdy2;

    assign slot_ready = slot_valid & src1_rdy & src2_rdy;
    assign iq_full    = &slot_valid;
    assign deq_valid  = |slot_ready;

    // Lowest free slot and lowest ready slot
    always_comb begin
        free_idx = '0;
        sel_idx  = '0;
        for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
            if (!slot_valid[i]) begin
                free_idx = IDX_W'(i);
            end
            if (slot_ready[i]) begin
                sel_idx = IDX_W'(i);
            end
        end
    end

    // Same-cycle writeback counts as ready at enqueue
    assign enq_rdy1 = !enq_src1_is_reg || !rs1_busy || (wb_valid && wb_prd == enq_prs1);
    assign enq_rdy2 = !enq_src2_is_reg || !rs2_busy || (wb_valid && wb_prd == enq_prs2);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            slot_valid <= '0;
            src1_rdy   <= '0;
            src2_rdy   <= '0;
        end else if (flush_valid) begin
            slot_valid <= '0;
        end else begin
            for (int i = 0; i < IQ_DEPTH; i++) begin
                if (wb_valid && slot_prs1[i] == wb_prd) begin
                    src1_rdy[i] <= 1'b1;
                end
                if (wb_valid && slot_prs2[i] == wb_prd) begin
                    src2_rdy[i] <= 1'b1;
                end
            end
            if (deq_valid && deq_ready) begin
                slot_valid[sel_idx] <= 1'b0;
            end
            if (enq) begin
                slot_valid[free_idx] <= 1'b1;
                src1_rdy[free_idx]   <= enq_rdy1;
                src2_rdy[free_idx]   <= enq_rdy2;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (enq) begin
            slot_robid[free_idx]       <= enq_robid;
            slot_pc[free_idx]          <= enq_pc;
            slot_instr[free_idx]       <= enq_instr;
            slot_prd[free_idx]         <= enq_prd;
            slot_prs1[free_idx]        <= enq_prs1;
            slot_prs2[free_idx]        <= enq_prs2;
            slot_src1_is_reg[free_idx] <= enq_src1_is_reg;
            slot_src2_is_reg[free_idx] <= enq_src2_is_reg;
        end
    end

    assign deq_robid       = slot_robid[sel_idx];
    assign deq_pc          = slot_pc[sel_idx];
    assign deq_instr       = slot_instr[sel_idx];
    assign deq_prd         = slot_prd[sel_idx];
    assign deq_prs1        = slot_prs1[sel_idx];
    assign deq_prs2        = slot_prs2[sel_idx];
    assign deq_src1_is_reg = slot_src1_is_reg[sel_idx];
    assign deq_src2_is_reg = slot_src2_is_reg[sel_idx];

endmodule

// ==== src/isu_top.sv ====
`timescale 1ns/1ns

module isu_top #(
    parameter int IQ_DEPTH = 4
) (
    input  logic                 clock,
    input  logic                 rst_n,
    // Dispatch from rename
    input  logic                 disp_valid,
    output logic                 disp_ready,
    input  isu_pkg::pc_t         disp_pc,
    input  isu_pkg::instr_t      disp_instr,
    input  isu_pkg::preg_t       disp_prd,
    input  logic                 disp_need_to_wb,
    input  isu_pkg::preg_t       disp_prs1,
    input  isu_pkg::preg_t       disp_prs2,
    input  logic                 disp_src1_is_reg,
    input  logic                 disp_src2_is_reg,
    // Writeback
    input  logic                 wb_valid,
    input  isu_pkg::robid_t      wb_robid,
    input  isu_pkg::preg_t       wb_prd,
    input  logic                 wb_need_to_wb,
    input  logic                 flush_valid,
    // Commit
    output logic                 commit_valid,
    output isu_pkg::pc_t         commit_pc,
    output isu_pkg::preg_t       commit_prd,
    output logic                 commit_need_to_wb,
    output isu_pkg::robid_t      commit_robid,
    // Issue to execute
    output logic                 deq_valid,
    input  logic                 deq_ready,
    output isu_pkg::robid_t      deq_robid,
    output isu_pkg::pc_t         deq_pc,
    output isu_pkg::instr_t      deq_instr,
    output isu_pkg::preg_t       deq_prd,
    output isu_pkg::preg_t       deq_prs1,
    output isu_pkg::preg_t       deq_prs2,
    output logic                 deq_src1_is_reg,
    output logic                 deq_src2_is_reg,
    // Debug
    output isu_pkg::rob_state_t  rob_state,
    output logic                 rob_walk_valid,
    output isu_pkg::preg_t       rob_walk_prd
);
    import isu_pkg::*;

    logic   disp_ok;
    logic   disp_fire;
    logic   walk_step;
    logic   walk_need_to_wb;
    logic   rob_empty;
    logic   rob_full;
    logic   iq_full;
    logic   rs1_busy;
    logic   rs2_busy;
    robid_t rob_head;
    robid_t rob_tail;

    assign disp_ready     = disp_ok && !rob_full && !iq_full;
    assign disp_fire      = disp_valid && disp_ready;
    assign rob_walk_valid = walk_step;

    rob_walk_fsm u_rob_walk_fsm (
        .clock(clock), .rst_n(rst_n), .flush_valid(flush_valid), .rob_empty(rob_empty),
        .rob_state(rob_state), .disp_ok(disp_ok), .walk_step(walk_step)
    );

    rob_ptr u_rob_ptr (
        .clock(clock), .rst_n(rst_n), .enq(disp_fire), .deq(commit_valid),
        .walk_step(walk_step), .head(rob_head), .tail(rob_tail),
        .rob_empty(rob_empty), .rob_full(rob_full)
    );

    // Commit shares the dispatch gate: running and not flushing
    rob_store u_rob_store (
        .clock(clock), .rst_n(rst_n), .enq(disp_fire), .enq_id(rob_tail),
        .enq_pc(disp_pc), .enq_prd(disp_prd), .enq_need_to_wb(disp_need_to_wb),
        .wb_valid(wb_valid), .wb_robid(wb_robid), .head(rob_head), .tail(rob_tail),
        .commit_ok(disp_ok), .walk_step(walk_step), .commit_valid(commit_valid),
        .commit_pc(commit_pc), .commit_prd(commit_prd),
        .commit_need_to_wb(commit_need_to_wb), .commit_robid(commit_robid),
        .walk_prd(rob_walk_prd), .walk_need_to_wb(walk_need_to_wb)
    );

    busy_table u_busy_table (
        .clock(clock), .rst_n(rst_n), .alloc_en(disp_fire && disp_need_to_wb),
        .alloc_prd(disp_prd), .wb_valid(wb_valid), .wb_need_to_wb(wb_need_to_wb),
        .wb_prd(wb_prd), .walk_step(walk_step), .walk_need_to_wb(walk_need_to_wb),
        .walk_prd(rob_walk_prd), .rs1(disp_prs1), .rs2(disp_prs2),
        .rs1_busy(rs1_busy), .rs2_busy(rs2_busy)
    );

    issue_queue #(
        .IQ_DEPTH(IQ_DEPTH)
    ) u_issue_queue (
        .clock(clock), .rst_n(rst_n), .enq(disp_fire), .enq_robid(rob_tail),
        .enq_pc(disp_pc), .enq_instr(disp_instr), .enq_prd(disp_prd),
        .enq_prs1(disp_prs1), .enq_prs2(disp_prs2),
        .enq_src1_is_reg(disp_src1_is_reg), .enq_src2_is_reg(disp_src2_is_reg),
        .rs1_busy(rs1_busy), .rs2_busy(rs2_busy), .wb_valid(wb_valid), .wb_prd(wb_prd),
        .flush_valid(flush_valid), .iq_full(iq_full),
        .deq_valid(deq_valid), .deq_ready(deq_ready), .deq_robid(deq_robid),
        .deq_pc(deq_pc), .deq_instr(deq_instr), .deq_prd(deq_prd),
        .deq_prs1(deq_prs1), .deq_prs2(deq_prs2),
        .deq_src1_is_reg(deq_src1_is_reg), .deq_src2_is_reg(deq_src2_is_reg)
    );

endmodule

// ==== tests/isu_tb.sv ====
`timescale 1ns/1ns

module isu_tb;
    import isu_pkg::*;

    localparam int NUM_REC     = 16;
    localparam int CYCLE_LIMIT = 20 * NUM_REC + 200;

    logic       clock;
    logic       rst_n;
    logic       disp_valid;
    logic       disp_ready;
    pc_t        disp_pc;
    instr_t     disp_instr;
    preg_t      disp_prd;
    logic       disp_need_to_wb;
    preg_t      disp_prs1;
    preg_t      disp_prs2;
    logic       disp_src1_is_reg;
    logic       disp_src2_is_reg;
    logic       wb_valid;
    robid_t     wb_robid;
    preg_t      wb_prd;
    logic       wb_need_to_wb;
    logic       flush_valid;
    logic       commit_valid;
    pc_t        commit_pc;
    preg_t      commit_prd;
    logic       commit_need_to_wb;
    robid_t     commit_robid;
    logic       deq_valid;
    logic       deq_ready;
    robid_t     deq_robid;
    pc_t        deq_pc;
    instr_t     deq_instr;
    preg_t      deq_prd;
    preg_t      deq_prs1;
    preg_t      deq_prs2;
    logic       deq_src1_is_reg;
    logic       deq_src2_is_reg;
    rob_state_t rob_state;
    logic       rob_walk_valid;
    preg_t      rob_walk_prd;

    // Each row holds {pc offset, instr, prd, need_to_wb, prs1, prs2, src1_is_reg, src2_is_reg}
    logic [68:0] stim [NUM_REC];
    int          wb_order [6] = '{2, 0, 5, 1, 3, 4};

    pc_t    rec_pc [NUM_REC];
    instr_t rec_instr [NUM_REC];
    preg_t  rec_prd [NUM_REC];
    preg_t  rec_prs1 [NUM_REC];
    preg_t  rec_prs2 [NUM_REC];
    logic   rec_src1 [NUM_REC];
    logic   rec_src2 [NUM_REC];
    logic   rec_ntw [NUM_REC];
    robid_t rec_id [NUM_REC];
    bit     accepted [NUM_REC];
    bit     issued [NUM_REC];
    bit     flushed [NUM_REC];
    bit     wb_done [NUM_REC];
    bit     committed [NUM_REC];
    bit     pend1 [NUM_REC];
    bit     pend2 [NUM_REC];

    logic [63:0] busy_model;
    int          rob_q [$];
    int          walk_q [$];
    robid_t      next_id;
    int          cur_disp;
    int          cur_wb;
    int          cycles;
    logic [15:0] lfsr;
    logic        deq_hold;
    logic        seen_ready;
    logic        seen_deq;
    logic        seen_commit;
    logic        seen_walk;
    rob_state_t  seen_state;

    isu_top dut0 (
        .clock(clock), .rst_n(rst_n),
        .disp_valid(disp_valid), .disp_ready(disp_ready), .disp_pc(disp_pc),
        .disp_instr(disp_instr), .disp_prd(disp_prd), .disp_need_to_wb(disp_need_to_wb),
        .disp_prs1(disp_prs1), .disp_prs2(disp_prs2),
        .disp_src1_is_reg(disp_src1_is_reg), .disp_src2_is_reg(disp_src2_is_reg),
        .wb_valid(wb_valid), .wb_robid(wb_robid), .wb_prd(wb_prd),
        .wb_need_to_wb(wb_need_to_wb), .flush_valid(flush_valid),
        .commit_valid(commit_valid), .commit_pc(commit_pc), .commit_prd(commit_prd),
        .commit_need_to_wb(commit_need_to_wb), .commit_robid(commit_robid),
        .deq_valid(deq_valid), .deq_ready(deq_ready), .deq_robid(deq_robid),
        .deq_pc(deq_pc), .deq_instr(deq_instr), .deq_prd(deq_prd),
        .deq_prs1(deq_prs1), .deq_prs2(deq_prs2),
        .deq_src1_is_reg(deq_src1_is_reg), .deq_src2_is_reg(deq_src2_is_reg),
        .rob_state(rob_state), .rob_walk_valid(rob_walk_valid), .rob_walk_prd(rob_walk_prd)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic load_table();
        // Dependent chains first, then a block of eight and the flush pair
        stim[0]  = {16'h0100, 32'h00a00513, 6'd10, 1'b1, 6'd0,  6'd0,  1'b0, 1'b0};
        stim[1]  = {16'h0104, 32'h00150593, 6'd11, 1'b1, 6'd10, 6'd0,  1'b1, 1'b0};
        stim[2]  = {16'h0108, 32'h00208633, 6'd12, 1'b1, 6'd1,  6'd2,  1'b1, 1'b1};
        stim[3]  = {16'h010c, 32'h00c586b3, 6'd13, 1'b1, 6'd11, 6'd12, 1'b1, 1'b1};
        stim[4]  = {16'h0110, 32'h00d52023, 6'd14, 1'b0, 6'd13, 6'd10, 1'b1, 1'b1};
        stim[5]  = {16'h0114, 32'h00700793, 6'd15, 1'b1, 6'd0,  6'd0,  1'b0, 1'b0};
        stim[6]  = {16'h0140, 32'h00108a13, 6'd20, 1'b1, 6'd1,  6'd0,  1'b1, 1'b0};
        stim[7]  = {16'h0144, 32'h00200a93, 6'd21, 1'b1, 6'd0,  6'd0,  1'b0, 1'b0};
        stim[8]  = {16'h0148, 32'h00418b33, 6'd22, 1'b1, 6'd3,  6'd4,  1'b1, 1'b1};
        stim[9]  = {16'h014c, 32'h00300b93, 6'd23, 1'b1, 6'd0,  6'd0,  1'b0, 1'b0};
        stim[10] = {16'h0150, 32'h00120c13, 6'd24, 1'b1, 6'd2,  6'd0,  1'b1, 1'b0};
        stim[11] = {16'h0154, 32'h0041a023, 6'd25, 1'b0, 6'd3,  6'd4,  1'b1, 1'b1};
        stim[12] = {16'h0158, 32'h00500c93, 6'd26, 1'b1, 6'd0,  6'd0,  1'b0, 1'b0};
        stim[13] = {16'h015c, 32'h00600d13, 6'd27, 1'b1, 6'd0,  6'd0,  1'b0, 1'b0};
        stim[14] = {16'h0160, 32'h00800e13, 6'd28, 1'b1, 6'd0,  6'd0,  1'b0, 1'b0};
        stim[15] = {16'h0200, 32'h019b8c33, 6'd30, 1'b1, 6'd23, 6'd25, 1'b1, 1'b1};
    endtask

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return (s >> 1) ^ (s[0] ? 16'hb400 : 16'h0000);
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
        if (actual !== expected) begin
            stop_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h",
                               name, actual, expected));
        end
    endtask

    // Outputs are sampled at the falling edge once settled
    task automatic observe();
        int j;
        int hit;
        seen_ready  = disp_ready;
        seen_deq    = deq_valid;
        seen_commit = commit_valid;
        seen_walk   = rob_walk_valid;
        seen_state  = rob_state;
        if (wb_valid) begin
            wb_done[cur_wb] = 1'b1;
            if (wb_need_to_wb) begin
                busy_model[wb_prd] = 1'b0;
            end
            for (j = 0; j < NUM_REC; j++) begin
                if (rec_prs1[j] == wb_prd) begin
                    pend1[j] = 1'b0;
                end
                if (rec_prs2[j] == wb_prd) begin
                    pend2[j] = 1'b0;
                end
            end
        end
        if (commit_valid) begin
            if (rob_q.size() == 0) begin
                stop_run("commit_valid rose with no instruction in flight");
            end else begin
                j = rob_q.pop_front();
                check("commit_robid", commit_robid, rec_id[j]);
                check("commit_pc", commit_pc, rec_pc[j]);
                check("commit_prd", commit_prd, rec_prd[j]);
                check("commit_need_to_wb", commit_need_to_wb, rec_ntw[j]);
                if (!wb_done[j]) begin
                    stop_run("An instruction committed before its writeback");
                end
                committed[j] = 1'b1;
            end
        end
        if (rob_walk_valid) begin
            check("rob_state", rob_state, ROB_WALK);
            if (walk_q.size() == 0) begin
                stop_run("rob_walk_valid pulsed more often than entries were flushed");
            end else begin
                j = walk_q.pop_front();
                check("rob_walk_prd", rob_walk_prd, rec_prd[j]);
                if (rec_ntw[j]) begin
                    busy_model[rec_prd[j]] = 1'b0;
                end
                next_id = next_id - 1'b1;
            end
        end
        if (deq_valid && deq_ready) begin
            hit = -1;
            for (j = 0; j < NUM_REC; j++) begin
                if (accepted[j] && !issued[j] && !flushed[j] && rec_id[j] == deq_robid) begin
                    hit = j;
                end
            end
            if (hit < 0) begin
                stop_run("The issue port sent a robid that was not waiting in the queue");
            end else begin
                check("deq_pc", deq_pc, rec_pc[hit]);
                check("deq_instr", deq_instr, rec_instr[hit]);
                check("deq_prd", deq_prd, rec_prd[hit]);
                check("deq_prs1", deq_prs1, rec_prs1[hit]);
                check("deq_prs2", deq_prs2, rec_prs2[hit]);
                check("deq_src1_is_reg", deq_src1_is_reg, rec_src1[hit]);
                check("deq_src2_is_reg", deq_src2_is_reg, rec_src2[hit]);
                if (pend1[hit] || pend2[hit]) begin
                    stop_run("An instruction issued before its source was written back");
                end
                issued[hit] = 1'b1;
            end
        end
        if (disp_valid && disp_ready) begin
            j = cur_disp;
            accepted[j] = 1'b1;
            rec_id[j] = next_id;
            next_id = next_id + 1'b1;
            pend1[j] = disp_src1_is_reg && busy_model[disp_prs1];
            pend2[j] = disp_src2_is_reg && busy_model[disp_prs2];
            if (disp_need_to_wb) begin
                busy_model[disp_prd] = 1'b1;
            end
            rob_q.push_back(j);
        end
        // Walk order runs youngest first
        if (flush_valid) begin
            while (rob_q.size() > 0) begin
                j = rob_q.pop_back();
                flushed[j] = 1'b1;
                walk_q.push_back(j);
            end
        end
    endtask

    task automatic cycle();
        @(negedge clock);
        observe();
        @(posedge clock);
        #1;
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            stop_run($sformatf("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT));
        end
        if (deq_hold) begin
            deq_ready = 1'b0;
        end else begin
            lfsr = lfsr_step(lfsr);
            deq_ready = lfsr[0];
        end
    endtask

    task automatic dispatch(input int k);
        logic [15:0] pc_off;
        {pc_off, disp_instr, disp_prd, disp_need_to_wb, disp_prs1, disp_prs2,
         disp_src1_is_reg, disp_src2_is_reg} = stim[k];
        disp_pc = 64'h0000_0000_8000_0000 + pc_off;
        rec_pc[k] = disp_pc;
        rec_instr[k] = disp_instr;
        rec_prd[k] = disp_prd;
        rec_ntw[k] = disp_need_to_wb;
        rec_prs1[k] = disp_prs1;
        rec_prs2[k] = disp_prs2;
        rec_src1[k] = disp_src1_is_reg;
        rec_src2[k] = disp_src2_is_reg;
        cur_disp = k;
        disp_valid = 1'b1;
        while (!accepted[k]) begin
            cycle();
        end
        disp_valid = 1'b0;
    endtask

    task automatic wait_issued(input int k);
        while (!issued[k]) begin
            cycle();
        end
    endtask

    task automatic writeback(input int k);
        wait_issued(k);
        cur_wb = k;
        wb_robid = rec_id[k];
        wb_prd = rec_prd[k];
        wb_need_to_wb = rec_ntw[k];
        wb_valid = 1'b1;
        cycle();
        wb_valid = 1'b0;
    endtask

    task automatic drain();
        while (rob_q.size() != 0) begin
            cycle();
        end
    endtask

    initial begin
        int k;
        int n;
        int low_cycles;
        load_table();
        rst_n = 1'b0;
        disp_valid = 1'b0;
        disp_pc = '0;
        disp_instr = '0;
        disp_prd = '0;
        disp_need_to_wb = 1'b0;
        disp_prs1 = '0;
        disp_prs2 = '0;
        disp_src1_is_reg = 1'b0;
        disp_src2_is_reg = 1'b0;
        wb_valid = 1'b0;
        wb_robid = '0;
        wb_prd = '0;
        wb_need_to_wb = 1'b0;
        flush_valid = 1'b0;
        deq_ready = 1'b0;
        deq_hold = 1'b0;
        lfsr = 16'd39129;
        next_id = '0;
        busy_model = '0;
        cur_disp = 0;
        cur_wb = 0;
        cycles = 0;
        repeat (2) @(posedge clock);
        #1;
        rst_n = 1'b1;

        cycle();
        check("disp_ready", seen_ready, 1'b1);
        check("deq_valid", seen_deq, 1'b0);
        check("commit_valid", seen_commit, 1'b0);
        check("rob_walk_valid", seen_walk, 1'b0);
        check("rob_state", seen_state, ROB_RUN);

        // Out-of-order writebacks still commit in id order
        for (k = 0; k < 6; k++) begin
            dispatch(k);
        end
        for (k = 0; k < 6; k++) begin
            writeback(wb_order[k]);
        end
        drain();

        // Eight in flight fill the ROB
        for (k = 6; k < 14; k++) begin
            dispatch(k);
        end
        cycle();
        check("disp_ready", seen_ready, 1'b0);
        writeback(6);
        while (!seen_ready) begin
            cycle();
        end
        check("committed_oldest", committed[6], 1'b1);

        for (k = 7; k < 14; k++) begin
            wait_issued(k);
        end

        // Park one ready instruction so the flush has to empty the queue
        deq_hold = 1'b1;
        deq_ready = 1'b0;
        dispatch(14);
        cycle();
        check("deq_valid", seen_deq, 1'b1);
        n = rob_q.size();
        check("entries_in_flight", n, ROB_DEPTH);
        flush_valid = 1'b1;
        cycle();
        flush_valid = 1'b0;
        deq_hold = 1'b0;
        low_cycles = 0;
        while (!seen_ready) begin
            low_cycles++;
            cycle();
            check("deq_valid", seen_deq, 1'b0);
        end
        check("disp_ready_low_cycles", low_cycles, n + 2);
        check("entries_left_to_walk", walk_q.size(), 0);

        // Reads a register that the walk freed
        dispatch(15);
        wait_issued(15);
        writeback(15);
        drain();

        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== all.f ====
src/isu_pkg.sv
src/rob_walk_fsm.sv
src/rob_ptr.sv
src/rob_store.sv
src/busy_table.sv
src/issue_queue.sv
src/isu_top.sv
tests/isu_tb.sv

// ==== Bender.yml ====
package:
  name: isu

sources:
  - src/isu_pkg.sv
  - src/rob_walk_fsm.sv
  - src/rob_ptr.sv
  - src/rob_store.sv
  - src/busy_table.sv
  - src/issue_queue.sv
  - src/isu_top.sv
  - target: test
    files:
      - tests/isu_tb.sv
